// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary -Wno-fatal --top-module fetch_tb -f all.f -Mdir build

run: compile
	@out=$$(./build/Vfetch_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf build

// ==== all.f ====
+incdir+dv
source/y86_isa_pkg.sv
source/fetch_regs_pkg.sv
source/instr_mem.sv
source/fetch.sv
source/pc_control.sv
source/axil_ctrl.sv
source/fetch_top.sv
dv/fetch_tb.sv

// ==== dv/fetch_ref.svh ====
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

typedef struct packed {
  logic [63:0] pc;
  logic [3:0]  icode;
  logic [3:0]  ifun;
  logic [3:0]  ra;
  logic [3:0]  rb;
  logic [63:0] valc;
  logic [63:0] valp;
  logic [1:0]  stat;
  logic [63:0] next_pc;
  logic        stop;
  logic        ret;
} rec_t;

logic [7:0] img [MEM_BYTES];  // Mirror of what the host wrote

function automatic logic [7:0] img_byte(input logic [63:0] a);
  if (a < 64'(MEM_BYTES))
    return img[a[$clog2(MEM_BYTES)-1:0]];
  return 8'h00;  // Past the end reads zero
endfunction

function automatic rec_t fetch_ref(input logic [63:0] pc);
  rec_t        r;
  logic [7:0]  b0;
  logic [7:0]  b1;
  logic        regs;
  logic        cst;
  logic        jmp;
  logic [63:0] off;
  r = '0;
  b0 = img_byte(pc);
  b1 = img_byte(pc + 64'd1);
  r.pc = pc;
  r.icode = b0[7:4];
  r.ifun = b0[3:0];
  regs = r.icode inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hA, 4'hB};
  cst = r.icode inside {4'h3, 4'h4, 4'h5, 4'h7, 4'h8};
  jmp = r.icode inside {4'h7, 4'h8};
  r.ra = regs ? b1[7:4] : 4'hF;
  r.rb = regs ? b1[3:0] : 4'hF;
  off = jmp ? 64'd1 : 64'd2;  // Constant follows opcode or register byte
  if (cst)
    for (int i = 0; i < 8; i++)
      r.valc[8*i +: 8] = img_byte(pc + off + 64'(i));
  r.valp = pc + 64'd1 + (regs ? 64'd1 : 64'd0) + (cst ? 64'd8 : 64'd0);
  if (pc + 64'd9 >= 64'(MEM_BYTES))  // Tenth window byte past the end
    r.stat = 2'd2;
  else if (r.icode > 4'hB)
    r.stat = 2'd3;
  else if (r.icode == 4'h0)
    r.stat = 2'd1;
  else
    r.stat = 2'd0;
  r.ret = (r.stat == 2'd0) && (r.icode == 4'h9);
  r.stop = (r.stat != 2'd0) || r.ret;
  r.next_pc = jmp ? r.valc : r.valp;
  return r;
endfunction

`endif

// ==== dv/fetch_tb.sv ====
module fetch_tb import y86_isa_pkg::*, fetch_regs_pkg::*;;

  localparam int MEM_BYTES = 1024;

  `include "fetch_ref.svh"

  logic                  clk;
  logic                  reset;
  logic [AXI_ADDR_W-1:0] s_awaddr;
  logic                  s_awvalid;
  logic                  s_awready;
  logic [31:0]           s_wdata;
  logic [3:0]            s_wstrb;
  logic                  s_wvalid;
  logic                  s_wready;
  logic [1:0]            s_bresp;
  logic                  s_bvalid;
  logic                  s_bready;
  logic [AXI_ADDR_W-1:0] s_araddr;
  logic                  s_arvalid;
  logic                  s_arready;
  logic [31:0]           s_rdata;
  logic [1:0]            s_rresp;
  logic                  s_rvalid;
  logic                  s_rready;
  logic                  out_valid;
  logic                  out_ready = 1'b0;
  logic [63:0]           out_pc;
  logic [3:0]            out_icode;
  logic [3:0]            out_ifun;
  logic [3:0]            out_ra;
  logic [3:0]            out_rb;
  logic [63:0]           out_valc;
  logic [63:0]           out_valp;
  stat_t                 out_stat;

  logic [31:0] lfsr = 32'hf180f733;
  rec_t        exp_q[$];
  rec_t        exp_rec;
  rec_t        last_rec;
  logic        rand_ready = 1'b0;
  int          errors = 0;
  int          tests = 0;
  int          failed = 0;
  int          wp;

  fetch_top #(.MEM_BYTES(MEM_BYTES)) dut (.*);

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  // Galois LFSR stepped once per bit
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], rand_bit()};
    return v;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic void emit(input logic [7:0] b);
    img[wp] = b;
    wp++;
  endfunction

  function automatic void emit_quad(input logic [63:0] v);
    for (int i = 0; i < 8; i++)
      emit(v[8*i +: 8]);  // Little endian
  endfunction

  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int   n;
    logic aw_hs;
    logic w_hs;
    logic aw_done;
    logic w_done;
    logic got_b;
    aw_done = 1'b0;
    w_done = 1'b0;
    got_b = 1'b0;
    resp = 2'b11;
    n = 0;
    @(posedge clk);
    s_awaddr <= addr;
    s_awvalid <= 1'b1;
    s_wdata <= data;
    s_wstrb <= 4'hF;
    s_wvalid <= 1'b1;
    s_bready <= 1'b1;
    while (!(aw_done && w_done) && n < 50)
    begin
      @(negedge clk);
      aw_hs = s_awvalid && s_awready;
      w_hs = s_wvalid && s_wready;
      @(posedge clk);
      if (aw_hs)
      begin
        aw_done = 1'b1;
        s_awvalid <= 1'b0;
      end
      if (w_hs)
      begin
        w_done = 1'b1;
        s_wvalid <= 1'b0;
      end
      n++;
    end
    if (!(aw_done && w_done))
    begin
      $display("write to %h was not accepted in time", addr);
      errors++;
    end
    n = 0;
    while (!got_b && n < 50)
    begin
      @(negedge clk);
      got_b = s_bvalid;
      n++;
    end
    if (got_b)
      resp = s_bresp;
    else
    begin
      $display("no write response for %h in time", addr);
      errors++;
    end
    @(posedge clk);
    s_bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int   n;
    logic ar_done;
    logic got_r;
    ar_done = 1'b0;
    got_r = 1'b0;
    data = '0;
    resp = 2'b11;
    n = 0;
    @(posedge clk);
    s_araddr <= addr;
    s_arvalid <= 1'b1;
    s_rready <= 1'b1;
    while (!ar_done && n < 50)
    begin
      @(negedge clk);
      ar_done = s_arready;
      @(posedge clk);
      n++;
    end
    s_arvalid <= 1'b0;
    n = 0;
    while (!got_r && n < 50)
    begin
      @(negedge clk);
      got_r = s_rvalid;
      n++;
    end
    if (ar_done && got_r)
    begin
      data = s_rdata;
      resp = s_rresp;
    end
    else
    begin
      $display("read of %h did not complete in time", addr);
      errors++;
    end
    @(posedge clk);
    s_rready <= 1'b0;
  endtask

  task automatic load_range(input int lo, input int hi);
    logic [1:0] resp;
    for (int w = lo / 4; w <= hi / 4; w++)
    begin
      axil_write(IMEM_BASE + 16'(4 * w),
                 {img[4*w+3], img[4*w+2], img[4*w+1], img[4*w]}, resp);
      check_val("s_bresp", 64'(resp), 64'(RESP_OKAY));
    end
  endtask

  // Walk the predicted path, then start fetch and wait for it to drain
  task automatic run_program(input logic [31:0] start_pc);
    logic [63:0] pc;
    logic [31:0] data;
    logic [1:0]  resp;
    int          n;
    pc = 64'(start_pc);
    for (n = 0; n < 64; n++)
    begin
      last_rec = fetch_ref(pc);
      exp_q.push_back(last_rec);
      if (last_rec.stop)
        break;
      pc = last_rec.next_pc;
    end
    axil_write(ADDR_START_PC, start_pc, resp);
    axil_write(ADDR_CTRL, 32'd1, resp);
    n = 0;
    while (exp_q.size() != 0 && n < 2000)
    begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      $display("fetch stopped with %0d records missing", exp_q.size());
      errors++;
      exp_q.delete();
    end
    repeat (20) @(negedge clk);  // Quiet window where extra records get flagged
    axil_read(ADDR_STATUS, data, resp);
    check_val("status_stat", 64'(data[1:0]), 64'(last_rec.stat));
    check_val("status_ret", 64'(data[STATUS_RET_BIT]), 64'(last_rec.ret));
    axil_read(ADDR_CTRL, data, resp);
    check_val("running", 64'(data[CTRL_RUN_BIT]), 64'd0);
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors != err_before)
      failed++;
    $display("test %s: %s", name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  always @(posedge clk)
  begin
    if (reset)
      out_ready <= 1'b0;
    else
      out_ready <= rand_ready ? rand_bit() : 1'b1;
  end

  // Comparison of each transferred record
  always @(negedge clk)
  begin
    if (!reset && out_valid && out_ready)
    begin
      if (exp_q.size() == 0)
      begin
        $display("unexpected record at pc %h after the stop record", out_pc);
        errors++;
      end
      else
      begin
        exp_rec = exp_q.pop_front();
        check_val("out_pc", out_pc, exp_rec.pc);
        check_val("out_icode", 64'(out_icode), 64'(exp_rec.icode));
        check_val("out_ifun", 64'(out_ifun), 64'(exp_rec.ifun));
        check_val("out_ra", 64'(out_ra), 64'(exp_rec.ra));
        check_val("out_rb", 64'(out_rb), 64'(exp_rec.rb));
        check_val("out_valc", out_valc, exp_rec.valc);
        check_val("out_valp", out_valp, exp_rec.valp);
        check_val("out_stat", 64'(out_stat), 64'(exp_rec.stat));
      end
    end
  end

  initial
  begin
    logic [31:0] data;
    logic [1:0]  resp;
    logic [3:0]  code;
    logic [3:0]  classes [8];
    int          e0;
    classes = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'hA, 4'hB};
    reset = 1'b1;
    s_awaddr <= '0;
    s_awvalid <= 1'b0;
    s_wdata <= '0;
    s_wstrb <= '0;
    s_wvalid <= 1'b0;
    s_bready <= 1'b0;
    s_araddr <= '0;
    s_arvalid <= 1'b0;
    s_rready <= 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    for (int a = 0; a < MEM_BYTES; a++)
      img[a] = 8'(a) ^ 8'(a >> 5) ^ 8'h5a;  // Fill over all address bits
    load_range(0, MEM_BYTES - 1);

    e0 = errors;
    wp = 0;
    emit(8'h10);
    emit(8'h21);
    emit(8'h34);
    emit(8'h30);
    emit(8'hF2);
    emit_quad(64'h0123456789abcdef);
    emit(8'h40);
    emit(8'h15);
    emit_quad(64'h100);
    emit(8'h50);
    emit(8'h67);
    emit_quad(64'h18);
    emit(8'h61);
    emit(8'h89);
    emit(8'h73);
    emit_quad(64'(wp + 8));  // Jump to the next instruction
    emit(8'h80);
    emit_quad(64'h60);
    wp = 'h60;
    emit(8'hA0);
    emit(8'h8F);
    emit(8'hB0);
    emit(8'h9F);
    emit(8'h00);
    load_range(0, 'h7f);
    run_program(32'h0);
    end_test("all icodes to halt", e0);

    e0 = errors;
    wp = 'h100;
    for (int i = 0; i < 12; i++)
    begin
      code = classes[i % 8];
      emit({code, 4'(rand_bits(4))});
      if (code != 4'h1)
        emit(8'(rand_bits(8)));
      if (code inside {4'h3, 4'h4, 4'h5})
        emit_quad({rand_bits(32), rand_bits(32)});
    end
    emit(8'h00);
    load_range('h100, wp);
    run_program(32'h100);
    end_test("register and constant layout", e0);

    e0 = errors;
    wp = 'h200;
    emit(8'h70);
    emit_quad(64'h240);
    wp = 'h240;
    emit(8'h80);
    emit_quad(64'h280);
    wp = 'h280;
    emit(8'h10);
    emit(8'h90);
    load_range('h200, 'h28f);
    run_program(32'h200);
    end_test("jump, call and ret", e0);

    e0 = errors;
    wp = 'h300;
    emit(8'h10);
    emit(8'hC0);
    load_range('h300, 'h30f);
    run_program(32'h300);
    run_program(32'(MEM_BYTES - 9));
    end_test("invalid icode and address error", e0);

    e0 = errors;
    rand_ready <= 1'b1;
    run_program(32'h100);
    rand_ready <= 1'b0;
    end_test("back-pressure", e0);

    e0 = errors;
    axil_write(IMEM_BASE + 16'h3F0, 32'hcafe1234, resp);
    {img['h3F3], img['h3F2], img['h3F1], img['h3F0]} = 32'hcafe1234;
    axil_read(IMEM_BASE + 16'h3F0, data, resp);
    check_val("s_rdata", 64'(data), 64'hcafe1234);
    check_val("s_rresp", 64'(resp), 64'(RESP_OKAY));
    axil_read(16'h0800, data, resp);
    check_val("s_rresp", 64'(resp), 64'(RESP_SLVERR));
    axil_write(16'h0020, 32'h1, resp);
    check_val("s_bresp", 64'(resp), 64'(RESP_SLVERR));
    end_test("host access", e0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== source/axil_ctrl.sv ====
module axil_ctrl import fetch_regs_pkg::*, y86_isa_pkg::*; #(
  parameter int MEM_BYTES = 1024,
  localparam int WORD_AW = $clog2(MEM_BYTES / 4)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [AXI_ADDR_W-1:0] s_awaddr,
  input  logic                  s_awvalid,
  output logic                  s_awready,
  input  logic [31:0]           s_wdata,
  input  logic [3:0]            s_wstrb,
  input  logic                  s_wvalid,
  output logic                  s_wready,
  output logic [1:0]            s_bresp,
  output logic                  s_bvalid,
  input  logic                  s_bready,
  input  logic [AXI_ADDR_W-1:0] s_araddr,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  output logic [31:0]           s_rdata,
  output logic [1:0]            s_rresp,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  input  logic                  running,
  input  stat_t                 status_stat,
  input  logic                  status_ret,
  input  logic [63:0]           pc,
  input  logic [31:0]           mem_rdata,
  output logic                  mem_we,
  output logic [WORD_AW-1:0]    mem_waddr,
  output logic [31:0]           mem_wdata,
  output logic [3:0]            mem_wstrb,
  output logic [WORD_AW-1:0]    mem_raddr,
  output logic [31:0]           start_pc,
  output logic                  start
);

  logic                  aw_seen;
  logic                  w_seen;
  logic [AXI_ADDR_W-1:0] aw_addr;
  logic [31:0]           w_data;
  logic [3:0]            w_strb;
  logic                  wr_go;
  logic [AXI_ADDR_W-1:0] ar_addr;
  logic [31:0]           rd_reg;
  logic                  rd_from_mem;
  logic [31:0]           reg_rdata;
  logic                  reg_hit;

  function automatic logic in_mem(input logic [AXI_ADDR_W-1:0] addr);
    return (addr >= IMEM_BASE) && (32'(addr) < 32'(IMEM_BASE) + 32'(MEM_BYTES));
  endfunction

  function automatic logic [WORD_AW-1:0] mem_word(input logic [AXI_ADDR_W-1:0] addr);
    logic [AXI_ADDR_W-1:0] off;
    off = addr - IMEM_BASE;
    return off[WORD_AW+1:2];
  endfunction

  // Write side, AW and W in either order
  assign s_awready = !aw_seen;
  assign s_wready  = !w_seen;
  assign wr_go     = aw_seen && w_seen && !s_bvalid;  // Waits for previous B

  assign mem_we    = wr_go && in_mem(aw_addr);
  assign mem_waddr = mem_word(aw_addr);
  assign mem_wdata = w_data;
  assign mem_wstrb = w_strb;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      aw_seen  <= 1'b0;
      w_seen   <= 1'b0;
      s_bvalid <= 1'b0;
      s_bresp  <= RESP_OKAY;
      start    <= 1'b0;
      start_pc <= '0;
    end
    else
    begin
      start <= 1'b0;  // One-cycle pulse
      if (s_awvalid && s_awready)
        aw_seen <= 1'b1;
      if (s_wvalid && s_wready)
        w_seen <= 1'b1;
      if (wr_go)
      begin
        aw_seen  <= 1'b0;
        w_seen   <= 1'b0;
        s_bvalid <= 1'b1;
        s_bresp  <= RESP_OKAY;
        case ({aw_addr[AXI_ADDR_W-1:2], 2'b00})
          ADDR_CTRL:
            start <= w_strb[0] && w_data[CTRL_RUN_BIT];
          ADDR_START_PC:
          begin
            for (int i = 0; i < 4; i++)
            begin
              if (w_strb[i])
                start_pc[8*i +: 8] <= w_data[8*i +: 8];
            end
          end
          ADDR_STATUS, ADDR_PC: ;  // Read only, write ignored
          default:
            if (!in_mem(aw_addr))
              s_bresp <= RESP_SLVERR;
        endcase
      end
      else if (s_bvalid && s_bready)
        s_bvalid <= 1'b0;
    end
  end

  // Read side; memory address follows AR until accepted, then holds
  assign s_arready = !s_rvalid;
  assign mem_raddr = mem_word(s_arready ? s_araddr : ar_addr);
  assign s_rdata   = rd_from_mem ? mem_rdata : rd_reg;

  always_comb
  begin
    reg_rdata = '0;
    reg_hit   = 1'b1;
    case ({s_araddr[AXI_ADDR_W-1:2], 2'b00})
      ADDR_CTRL:     reg_rdata[CTRL_RUN_BIT] = running;
      ADDR_START_PC: reg_rdata = start_pc;
      ADDR_STATUS:
      begin
        reg_rdata[STATUS_STAT_LSB +: 2] = status_stat;
        reg_rdata[STATUS_RET_BIT]       = status_ret;
      end
      ADDR_PC:       reg_rdata = pc[31:0];
      default:       reg_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      s_rvalid    <= 1'b0;
      s_rresp     <= RESP_OKAY;
      rd_from_mem <= 1'b0;
    end
    else if (s_arvalid && s_arready)
    begin
      s_rvalid    <= 1'b1;
      rd_from_mem <= in_mem(s_araddr);
      s_rresp     <= (reg_hit || in_mem(s_araddr)) ? RESP_OKAY : RESP_SLVERR;
    end
    else if (s_rvalid && s_rready)
      s_rvalid <= 1'b0;
  end

  // Captured addresses and data
  always_ff @(posedge clk)
  begin
    if (s_awvalid && s_awready)
      aw_addr <= s_awaddr;
    if (s_wvalid && s_wready)
    begin
      w_data <= s_wdata;
      w_strb <= s_wstrb;
    end
    if (s_arvalid && s_arready)
    begin
      ar_addr <= s_araddr;
      rd_reg  <= reg_rdata;
    end
  end

endmodule

// ==== source/fetch.sv ====
module fetch import y86_isa_pkg::*; #(
  parameter int MEM_BYTES = 1024
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [63:0] pc,
  input  logic        fetch_en,
  input  logic [79:0] window,
  input  logic        window_err,
  input  logic        out_ready,
  output logic [63:0] fetch_addr,
  output logic        take,
  output logic [63:0] next_pc,
  output logic        stop_now,
  output stat_t       stop_stat,
  output logic        stop_ret,
  output logic        out_valid,
  output logic [63:0] out_pc,
  output logic [3:0]  out_icode,
  output logic [3:0]  out_ifun,
  output logic [3:0]  out_ra,
  output logic [3:0]  out_rb,
  output logic [63:0] out_valc,
  output logic [63:0] out_valp,
  output stat_t       out_stat
);

  logic [3:0]  icode;
  logic [3:0]  ifun;
  logic        regids;
  logic        has_valc;
  logic [3:0]  ra;
  logic [3:0]  rb;
  logic [63:0] valc;
  logic [63:0] valp;
  logic        pc_oob;
  stat_t       stat;

  // Byte string in address order to a little-endian quad word
  function automatic logic [63:0] le64(input logic [63:0] bytes);
    logic [63:0] v;
    for (int i = 0; i < 8; i++)
    begin
      v[8*i +: 8] = bytes[63 - 8*i -: 8];
    end
    return v;
  endfunction

  assign fetch_addr = pc;

  assign icode    = window[79:76];
  assign ifun     = window[75:72];
  assign regids   = need_regids(icode);
  assign has_valc = need_valc(icode);
  assign ra       = regids ? window[71:68] : REG_NONE;
  assign rb       = regids ? window[67:64] : REG_NONE;

  always_comb
  begin
    if (!has_valc)
      valc = '0;
    else if (is_jump_call(icode))
      valc = le64(window[71:8]);  // Bytes 1 to 8
    else
      valc = le64(window[63:0]);  // Bytes 2 to 9
  end

  assign valp   = pc + 64'd1 + {63'd0, regids} + (has_valc ? 64'd8 : 64'd0);
  assign pc_oob = pc >= 64'(MEM_BYTES);

  always_comb
  begin
    if (window_err || pc_oob)
      stat = ADR;
    else if (!icode_valid(icode))
      stat = INS;
    else if (icode == HALT)
      stat = HLT;
    else
      stat = AOK;
  end

  // Predicted fetch address
  assign next_pc   = is_jump_call(icode) ? valc : valp;
  assign stop_ret  = (stat == AOK) && (icode == RET);
  assign stop_now  = (stat != AOK) || stop_ret;
  assign stop_stat = stat;

  assign take = fetch_en && (!out_valid || out_ready);  // Slot empty or draining

  always_ff @(posedge clk)
  begin
    if (reset)
      out_valid <= 1'b0;
    else if (take)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;
  end

  // Record payload, held under back-pressure
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      out_pc    <= pc;
      out_icode <= icode;
      out_ifun  <= ifun;
      out_ra    <= ra;
      out_rb    <= rb;
      out_valc  <= valc;
      out_valp  <= valp;
      out_stat  <= stat;
    end
  end

endmodule

// ==== source/fetch_regs_pkg.sv ====
package fetch_regs_pkg;

  localparam int AXI_ADDR_W = 16;

  // Host register map
  localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL     = 16'h0000;
  localparam logic [AXI_ADDR_W-1:0] ADDR_START_PC = 16'h0004;
  localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS   = 16'h0008;
  localparam logic [AXI_ADDR_W-1:0] ADDR_PC       = 16'h000C;

  // Program byte k sits at IMEM_BASE + k
  localparam logic [AXI_ADDR_W-1:0] IMEM_BASE     = 16'h1000;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam int CTRL_RUN_BIT    = 0;  // Write 1 to start, reads running
  localparam int STATUS_STAT_LSB = 0;  // Two bits of stop reason
  localparam int STATUS_RET_BIT  = 4;  // Stop came from a ret

endpackage

// ==== source/fetch_top.sv ====
module fetch_top import y86_isa_pkg::*, fetch_regs_pkg::*; #(
  parameter int MEM_BYTES = 1024,
  localparam int WORD_AW = $clog2(MEM_BYTES / 4)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [AXI_ADDR_W-1:0] s_awaddr,
  input  logic                  s_awvalid,
  output logic                  s_awready,
  input  logic [31:0]           s_wdata,
  input  logic [3:0]            s_wstrb,
  input  logic                  s_wvalid,
  output logic                  s_wready,
  output logic [1:0]            s_bresp,
  output logic                  s_bvalid,
  input  logic                  s_bready,
  input  logic [AXI_ADDR_W-1:0] s_araddr,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  output logic [31:0]           s_rdata,
  output logic [1:0]            s_rresp,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [63:0]           out_pc,
  output logic [3:0]            out_icode,
  output logic [3:0]            out_ifun,
  output logic [3:0]            out_ra,
  output logic [3:0]            out_rb,
  output logic [63:0]           out_valc,
  output logic [63:0]           out_valp,
  output stat_t                 out_stat
);

  logic               mem_we;
  logic [WORD_AW-1:0] mem_waddr;
  logic [31:0]        mem_wdata;
  logic [3:0]         mem_wstrb;
  logic [WORD_AW-1:0] mem_raddr;
  logic [31:0]        mem_rdata;
  logic [63:0]        fetch_addr;
  logic [79:0]        window;
  logic               window_err;
  logic [31:0]        start_pc;
  logic               start;
  logic [63:0]        pc;
  logic               fetch_en;
  logic               running;
  stat_t              status_stat;
  logic               status_ret;
  logic               take;
  logic [63:0]        next_pc;
  logic               stop_now;
  stat_t              stop_stat;
  logic               stop_ret;

  instr_mem #(.MEM_BYTES(MEM_BYTES)) u_instr_mem (
    .clk, .mem_we, .mem_waddr, .mem_wdata, .mem_wstrb, .mem_raddr,
    .fetch_addr, .mem_rdata, .window, .window_err
  );

  fetch #(.MEM_BYTES(MEM_BYTES)) u_fetch (
    .clk, .reset, .pc, .fetch_en, .window, .window_err, .out_ready,
    .fetch_addr, .take, .next_pc, .stop_now, .stop_stat, .stop_ret,
    .out_valid, .out_pc, .out_icode, .out_ifun, .out_ra, .out_rb,
    .out_valc, .out_valp, .out_stat
  );

  pc_control u_pc_control (
    .clk, .reset, .start, .start_pc, .take, .next_pc, .stop_now, .stop_stat,
    .stop_ret, .pc, .fetch_en, .running, .status_stat, .status_ret
  );

  axil_ctrl #(.MEM_BYTES(MEM_BYTES)) u_axil_ctrl (
    .clk, .reset,
    .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
    .s_bresp, .s_bvalid, .s_bready, .s_araddr, .s_arvalid, .s_arready,
    .s_rdata, .s_rresp, .s_rvalid, .s_rready,
    .running, .status_stat, .status_ret, .pc, .mem_rdata,
    .mem_we, .mem_waddr, .mem_wdata, .mem_wstrb, .mem_raddr, .start_pc, .start
  );

endmodule

// ==== source/instr_mem.sv ====
module instr_mem #(
  parameter int MEM_BYTES = 1024,
  localparam int MEM_AW = $clog2(MEM_BYTES),
  localparam int WORD_AW = $clog2(MEM_BYTES / 4)
) (
  input  logic               clk,
  input  logic               mem_we,
  input  logic [WORD_AW-1:0] mem_waddr,
  input  logic [31:0]        mem_wdata,
  input  logic [3:0]         mem_wstrb,
  input  logic [WORD_AW-1:0] mem_raddr,
  input  logic [63:0]        fetch_addr,
  output logic [31:0]        mem_rdata,
  output logic [79:0]        window,
  output logic               window_err
);

  logic [7:0] mem [MEM_BYTES];

  // Host port, byte lanes little endian
  always_ff @(posedge clk)
  begin
    if (mem_we)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (mem_wstrb[i])
          mem[{mem_waddr, 2'(i)}] <= mem_wdata[8*i +: 8];
      end
    end
    mem_rdata <= {mem[{mem_raddr, 2'd3}], mem[{mem_raddr, 2'd2}],
                  mem[{mem_raddr, 2'd1}], mem[{mem_raddr, 2'd0}]};
  end

  // Ten bytes from fetch_addr, first byte on top
  always_comb
  begin : window_read
    logic [63:0] addr;
    window = '0;
    for (int k = 0; k < 10; k++)
    begin
      addr = fetch_addr + 64'(k);
      if (addr < 64'(MEM_BYTES))
        window[79 - 8*k -: 8] = mem[addr[MEM_AW-1:0]];  // Past the end stays zero
    end
  end

  assign window_err = fetch_addr > 64'(MEM_BYTES - 10);  // Last byte beyond memory

endmodule

// ==== source/pc_control.sv ====
module pc_control import y86_isa_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic [31:0] start_pc,
  input  logic        take,
  input  logic [63:0] next_pc,
  input  logic        stop_now,
  input  stat_t       stop_stat,
  input  logic        stop_ret,
  output logic [63:0] pc,
  output logic        fetch_en,
  output logic        running,
  output stat_t       status_stat,
  output logic        status_ret
);

  // Start wins over a load in the same cycle
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc          <= '0;
      running     <= 1'b0;
      status_stat <= AOK;
      status_ret  <= 1'b0;
    end
    else if (start)
    begin
      pc          <= {32'd0, start_pc};  // Upper half always zero
      running     <= 1'b1;
      status_stat <= AOK;
      status_ret  <= 1'b0;
    end
    else if (take)
    begin
      pc <= next_pc;  // Advance with the record load
      if (stop_now)
      begin
        running     <= 1'b0;
        status_stat <= stop_stat;
        status_ret  <= stop_ret;
      end
    end
  end

  // Fetch runs only between start and a stop record
  assign fetch_en = running;

endmodule

// ==== source/y86_isa_pkg.sv ====
package y86_isa_pkg;

  typedef enum logic [3:0] {
    HALT   = 4'h0,
    NOP    = 4'h1,
    CMOVXX = 4'h2,
    IRMOVQ = 4'h3,
    RMMOVQ = 4'h4,
    MRMOVQ = 4'h5,
    OPQ    = 4'h6,
    JXX    = 4'h7,
    CALL   = 4'h8,
    RET    = 4'h9,
    PUSHQ  = 4'hA,
    POPQ   = 4'hB
  } icode_t;

  typedef enum logic [1:0] {
    AOK = 2'd0,
    HLT = 2'd1,
    ADR = 2'd2,
    INS = 2'd3
  } stat_t;

  localparam logic [3:0] REG_NONE = 4'hF;  // No register

  // Instruction carries a rA:rB byte after the opcode
  function automatic logic need_regids(input logic [3:0] icode);
    return icode inside {CMOVXX, IRMOVQ, RMMOVQ, MRMOVQ, OPQ, PUSHQ, POPQ};
  endfunction

  function automatic logic need_valc(input logic [3:0] icode);
    return icode inside {IRMOVQ, RMMOVQ, MRMOVQ, JXX, CALL};
  endfunction

  // Destination directly after opcode, also the predicted target
  function automatic logic is_jump_call(input logic [3:0] icode);
    return icode inside {JXX, CALL};
  endfunction

  function automatic logic icode_valid(input logic [3:0] icode);
    return icode <= POPQ;
  endfunction

endpackage
